// File: rtl/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // Everything on the shared bus is one byte wide.
    typedef logic [7:0] word_t;

    // Flags are C, V, Z and N, from bit 0 upward.
    typedef logic [3:0] flags_t;

    localparam int unsigned FLAG_C = 0;
    localparam int unsigned FLAG_V = 1;
    localparam int unsigned FLAG_Z = 2;
    localparam int unsigned FLAG_N = 3;

    // Output codes that pick the bus source.
    // Codes 0 to 3 select registers a to d. Every code of 8 or more that is not
    // listed here selects the external data input.
    localparam logic [3:0] OUT_FLAGS  = 4'd4;
    localparam logic [3:0] OUT_ADDSUB = 4'd5;
    localparam logic [3:0] OUT_ANDOR  = 4'd6;
    localparam logic [3:0] OUT_SHIFT  = 4'd7;
    localparam logic [3:0] OUT_XORNOT = 4'd10;

    // Load codes that pick the bus destination.
    // Codes 0 to 3 write registers a to d and codes 4 to 6 are unused.
    // Any code with bit 3 set leaves every register alone.
    localparam logic [3:0] LOAD_FLAGS = 4'd7;

    // Right operand code with a dedicated zero source.
    // Codes 4, 5 and 7 have no register behind them and read as zero too.
    localparam logic [2:0] ARG_R_ZERO = 3'd6;

endpackage

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire                 clk,
    input  wire                 rst_n,

    input  wire alu_pkg::word_t bus,
    input  wire [3:0]           loadctl,
    input  wire [1:0]           arg_l,
    input  wire [2:0]           arg_r,

    output alu_pkg::word_t      alu_arg_l,
    output alu_pkg::word_t      alu_arg_r,

    output alu_pkg::word_t      reg_a,
    output alu_pkg::word_t      reg_b,
    output alu_pkg::word_t      reg_c,
    output alu_pkg::word_t      reg_d
);

    alu_pkg::word_t regs [4];
    logic           load_en;

    // Only load codes 0 to 3 address a general register.
    assign load_en = (loadctl[3:2] == 2'b00);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs[0] <= '0;
            regs[1] <= '0;
            regs[2] <= '0;
            regs[3] <= '0;
        end else if (load_en) begin
            regs[loadctl[1:0]] <= bus;
        end
    end

    assign reg_a = regs[0];
    assign reg_b = regs[1];
    assign reg_c = regs[2];
    assign reg_d = regs[3];

    // The left operand always comes from one of the four registers.
    assign alu_arg_l = regs[arg_l];

    // The right operand has a zero source on code 6. The other upper codes
    // have nothing driving them, so they read as zero as well.
    always_comb begin
        case (arg_r)
            3'd0: begin
                alu_arg_r = regs[0];
            end
            3'd1: begin
                alu_arg_r = regs[1];
            end
            3'd2: begin
                alu_arg_r = regs[2];
            end
            3'd3: begin
                alu_arg_r = regs[3];
            end
            alu_pkg::ARG_R_ZERO: begin
                alu_arg_r = '0;
            end
            default: begin
                alu_arg_r = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/alu_core.sv
`timescale 1ns/10ps
`default_nettype none

module alu_core (
    input  wire alu_pkg::word_t alu_arg_l,
    input  wire alu_pkg::word_t alu_arg_r,
    input  wire                 alt,
    input  wire                 cin,

    output alu_pkg::word_t      addsub_res,
    output alu_pkg::word_t      andor_res,
    output alu_pkg::word_t      xornot_res,
    output alu_pkg::word_t      shift_res,

    output logic                addsub_c,
    output logic                addsub_v,
    output logic                shift_c
);

    alu_pkg::word_t addsub_rhs;
    logic [8:0]     addsub_sum;

    // Subtraction is l + ~r + cin, so cin = 1 means no borrow in.
    assign addsub_rhs = alt ? ~alu_arg_r : alu_arg_r;

    assign addsub_sum = {1'b0, alu_arg_l} + {1'b0, addsub_rhs} + {8'b0, cin};

    assign addsub_res = addsub_sum[7:0];
    assign addsub_c   = addsub_sum[8];

    // Signed overflow: both addends share a sign and the sum has the other.
    assign addsub_v = (alu_arg_l[7] == addsub_rhs[7]) &&
                      (addsub_res[7] != alu_arg_l[7]);

    always_comb begin
        if (alt) begin
            andor_res = alu_arg_l | alu_arg_r;
        end else begin
            andor_res = alu_arg_l & alu_arg_r;
        end
    end

    // The not variant ignores the right operand.
    always_comb begin
        if (alt) begin
            xornot_res = ~alu_arg_l;
        end else begin
            xornot_res = alu_arg_l ^ alu_arg_r;
        end
    end

    // Shift left pulls cin into bit 0 and pushes bit 7 out as carry.
    // Swap leaves the carry path as a plain pass of cin.
    always_comb begin
        if (alt) begin
            shift_res = {alu_arg_l[3:0], alu_arg_l[7:4]};
            shift_c   = cin;
        end else begin
            shift_res = {alu_arg_l[6:0], cin};
            shift_c   = alu_arg_l[7];
        end
    end

endmodule

`default_nettype wire

// File: rtl/bus_driver.sv
`timescale 1ns/10ps
`default_nettype none

module bus_driver (
    input  wire [3:0]           outctl,
    input  wire alu_pkg::word_t bus_in,

    input  wire alu_pkg::word_t reg_a,
    input  wire alu_pkg::word_t reg_b,
    input  wire alu_pkg::word_t reg_c,
    input  wire alu_pkg::word_t reg_d,

    input  wire alu_pkg::word_t addsub_res,
    input  wire alu_pkg::word_t andor_res,
    input  wire alu_pkg::word_t xornot_res,
    input  wire alu_pkg::word_t shift_res,

    input  wire alu_pkg::flags_t fout,

    input  wire                 addsub_c,
    input  wire                 addsub_v,
    input  wire                 shift_c,

    output alu_pkg::word_t      bus,
    output logic                alu_c,
    output logic                alu_v
);

    // One decode of the output code picks the bus source. The carry and
    // overflow follow whichever ALU unit owns the bus this cycle.
    always_comb begin
        bus   = bus_in;
        alu_c = 1'b0;
        alu_v = 1'b0;

        case (outctl)
            4'd0: bus = reg_a;
            4'd1: bus = reg_b;
            4'd2: bus = reg_c;
            4'd3: bus = reg_d;
            alu_pkg::OUT_FLAGS: begin
                bus = {4'b0000, fout};
            end
            alu_pkg::OUT_ADDSUB: begin
                bus   = addsub_res;
                alu_c = addsub_c;
                alu_v = addsub_v;
            end
            alu_pkg::OUT_ANDOR: begin
                bus = andor_res;
            end
            alu_pkg::OUT_SHIFT: begin
                bus   = shift_res;
                alu_c = shift_c;
            end
            alu_pkg::OUT_XORNOT: begin
                bus = xornot_res;
            end
            // The remaining high codes select the external input.
            default: begin
                bus = bus_in;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/flags_reg.sv
`timescale 1ns/10ps
`default_nettype none

module flags_reg (
    input  wire                 clk,
    input  wire                 rst_n,

    input  wire alu_pkg::word_t bus,
    input  wire [3:0]           loadctl,
    input  wire                 calcfn,

    input  wire                 alu_c,
    input  wire                 alu_v,

    output alu_pkg::flags_t     fout
);

    alu_pkg::flags_t calc_flags;

    // Z and N are taken from whatever the bus carries this cycle.
    always_comb begin
        calc_flags                 = '0;
        calc_flags[alu_pkg::FLAG_C] = alu_c;
        calc_flags[alu_pkg::FLAG_V] = alu_v;
        calc_flags[alu_pkg::FLAG_Z] = (bus == '0);
        calc_flags[alu_pkg::FLAG_N] = bus[7];
    end

    // A direct load from the bus takes priority over a calculation.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fout <= '0;
        end else if (loadctl == alu_pkg::LOAD_FLAGS) begin
            fout <= bus[3:0];
        end else if (!calcfn) begin
            fout <= calc_flags;
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu_block.sv
`timescale 1ns/10ps
`default_nettype none

module alu_block (
    input  wire                 clk,
    input  wire                 rst_n,

    input  wire alu_pkg::word_t bus_in,

    input  wire [3:0]           outctl,
    input  wire [3:0]           loadctl,
    input  wire [1:0]           arg_l,
    input  wire [2:0]           arg_r,
    input  wire                 alt,
    input  wire                 calcfn,
    input  wire                 cin,

    output wire alu_pkg::word_t bus_out,
    output wire alu_pkg::flags_t fout
);

    wire alu_pkg::word_t alu_arg_l;
    wire alu_pkg::word_t alu_arg_r;

    wire alu_pkg::word_t reg_a;
    wire alu_pkg::word_t reg_b;
    wire alu_pkg::word_t reg_c;
    wire alu_pkg::word_t reg_d;

    wire alu_pkg::word_t addsub_res;
    wire alu_pkg::word_t andor_res;
    wire alu_pkg::word_t xornot_res;
    wire alu_pkg::word_t shift_res;

    wire addsub_c;
    wire addsub_v;
    wire shift_c;
    wire alu_c;
    wire alu_v;

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus_out),
        .loadctl   (loadctl),
        .arg_l     (arg_l),
        .arg_r     (arg_r),
        .alu_arg_l (alu_arg_l),
        .alu_arg_r (alu_arg_r),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .reg_c     (reg_c),
        .reg_d     (reg_d)
    );

    alu_core u_alu_core (
        .alu_arg_l  (alu_arg_l),
        .alu_arg_r  (alu_arg_r),
        .alt        (alt),
        .cin        (cin),
        .addsub_res (addsub_res),
        .andor_res  (andor_res),
        .xornot_res (xornot_res),
        .shift_res  (shift_res),
        .addsub_c   (addsub_c),
        .addsub_v   (addsub_v),
        .shift_c    (shift_c)
    );

    // The driven bus value is the block output and feeds every loader.
    bus_driver u_bus_driver (
        .outctl     (outctl),
        .bus_in     (bus_in),
        .reg_a      (reg_a),
        .reg_b      (reg_b),
        .reg_c      (reg_c),
        .reg_d      (reg_d),
        .addsub_res (addsub_res),
        .andor_res  (andor_res),
        .xornot_res (xornot_res),
        .shift_res  (shift_res),
        .fout       (fout),
        .addsub_c   (addsub_c),
        .addsub_v   (addsub_v),
        .shift_c    (shift_c),
        .bus        (bus_out),
        .alu_c      (alu_c),
        .alu_v      (alu_v)
    );

    flags_reg u_flags_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (bus_out),
        .loadctl (loadctl),
        .calcfn  (calcfn),
        .alu_c   (alu_c),
        .alu_v   (alu_v),
        .fout    (fout)
    );

endmodule

`default_nettype wire

// File: dv/alu_block_tb.sv
`timescale 1ns/10ps
`default_nettype none

module alu_block_tb;

    localparam int HALF_PERIOD   = 4;
    localparam int RANDOM_CYCLES = 400;
    // Reset and the directed part take fewer than 100 cycles.
    localparam int MAX_CYCLES    = RANDOM_CYCLES + 200;

    logic            clk;
    logic            rst_n;
    alu_pkg::word_t  bus_in;
    logic [3:0]      outctl;
    logic [3:0]      loadctl;
    logic [1:0]      arg_l;
    logic [2:0]      arg_r;
    logic            alt;
    logic            calcfn;
    logic            cin;
    alu_pkg::word_t  bus_out;
    alu_pkg::flags_t fout;

    alu_pkg::word_t  sh_regs [4];
    alu_pkg::flags_t sh_flags;
    alu_pkg::word_t  exp_bus;
    alu_pkg::flags_t exp_flags;
    logic            exp_we;
    logic [1:0]      exp_idx;
    logic            checking;
    int              cycle_cnt = 0;
    integer          seed;
    logic [31:0]     rnd;

    alu_block UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_in  (bus_in),
        .outctl  (outctl),
        .loadctl (loadctl),
        .arg_l   (arg_l),
        .arg_r   (arg_r),
        .alt     (alt),
        .calcfn  (calcfn),
        .cin     (cin),
        .bus_out (bus_out),
        .fout    (fout)
    );

    always #HALF_PERIOD clk = ~clk;

    // Expected bus value for one cycle, plus the flags and register write it causes.
    function automatic alu_pkg::word_t predict_cycle(
        input  logic [3:0]      oc,
        input  logic [3:0]      lc,
        input  logic [1:0]      al,
        input  logic [2:0]      ar,
        input  logic            a,
        input  logic            cf,
        input  logic            ci,
        input  alu_pkg::word_t  bi,
        output alu_pkg::flags_t nf,
        output logic            we,
        output logic [1:0]      idx
    );
        alu_pkg::word_t l;
        alu_pkg::word_t r;
        alu_pkg::word_t b;
        logic           c;
        logic           v;
        int             u;
        int             s;
        int             sl;
        int             sr;

        l  = sh_regs[al];
        r  = ar[2] ? 8'h00 : sh_regs[ar[1:0]];
        sl = int'($signed(l));
        sr = int'($signed(r));
        b  = bi;
        c  = 1'b0;
        v  = 1'b0;
        case (oc)
            4'd0, 4'd1, 4'd2, 4'd3: b = sh_regs[oc[1:0]];
            alu_pkg::OUT_FLAGS: b = {4'b0000, sh_flags};
            alu_pkg::OUT_ADDSUB: begin
                // Subtraction borrows one when cin is low.
                if (a) begin
                    u = int'(l) - int'(r) - (1 - int'(ci));
                    s = sl - sr - (1 - int'(ci));
                    c = (u >= 0);
                end else begin
                    u = int'(l) + int'(r) + int'(ci);
                    s = sl + sr + int'(ci);
                    c = (u > 255);
                end
                b = u[7:0];
                v = (s > 127) || (s < -128);
            end
            alu_pkg::OUT_ANDOR: b = a ? (l | r) : (l & r);
            alu_pkg::OUT_SHIFT: begin
                if (a) begin
                    b = (l << 4) | (l >> 4);
                    c = ci;
                end else begin
                    b = (l << 1) | {7'b0, ci};
                    c = l[7];
                end
            end
            alu_pkg::OUT_XORNOT: b = a ? ~l : (l ^ r);
            default: b = bi;
        endcase

        nf = sh_flags;
        if (lc == alu_pkg::LOAD_FLAGS) begin
            nf = b[3:0];
        end else if (!cf) begin
            nf[alu_pkg::FLAG_C] = c;
            nf[alu_pkg::FLAG_V] = v;
            nf[alu_pkg::FLAG_Z] = (b == 8'h00);
            nf[alu_pkg::FLAG_N] = b[7];
        end
        we  = (lc <= 4'd3);
        idx = lc[1:0];
        return b;
    endfunction

    task automatic check_word(input string name, input alu_pkg::word_t got,
                              input alu_pkg::word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "%s differs from the model", name);
        end
    endtask

    task automatic check_flags(input string name, input alu_pkg::flags_t got,
                               input alu_pkg::flags_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "%s differs from the model", name);
        end
    endtask

    // The bus is checked mid-cycle and the flags just after the edge, before new inputs.
    always @(negedge clk) begin
        if (checking) begin
            exp_bus = predict_cycle(outctl, loadctl, arg_l, arg_r, alt, calcfn, cin, bus_in,
                                    exp_flags, exp_we, exp_idx);
            check_word("bus_out", bus_out, exp_bus);
            @(posedge clk);
            #0.5;
            if (exp_we) begin
                sh_regs[exp_idx] = exp_bus;
            end
            sh_flags = exp_flags;
            check_flags("fout", fout, sh_flags);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic drive_cycle(input logic [3:0] oc, input logic [3:0] lc,
                               input logic [1:0] al, input logic [2:0] ar,
                               input logic a, input logic cf, input logic ci,
                               input alu_pkg::word_t bi);
        outctl  = oc;
        loadctl = lc;
        arg_l   = al;
        arg_r   = ar;
        alt     = a;
        calcfn  = cf;
        cin     = ci;
        bus_in  = bi;
        @(posedge clk);
        #1;
    endtask

    task automatic load_reg(input logic [3:0] lc, input alu_pkg::word_t value);
        drive_cycle(4'd8, lc, 2'd0, 3'd0, 1'b0, 1'b1, 1'b0, value);
    endtask

    task automatic read_bus(input logic [3:0] oc);
        drive_cycle(oc, 4'hF, 2'd0, 3'd0, 1'b0, 1'b1, 1'b0, 8'h00);
    endtask

    task automatic run_calc(input logic [3:0] oc, input logic [1:0] al,
                            input logic [2:0] ar, input logic a, input logic ci);
        drive_cycle(oc, 4'hF, al, ar, a, 1'b0, ci, 8'h00);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        bus_in   = 8'h00;
        outctl   = 4'd0;
        loadctl  = 4'hF;
        arg_l    = 2'd0;
        arg_r    = 3'd0;
        alt      = 1'b0;
        calcfn   = 1'b1;
        cin      = 1'b0;
        checking = 1'b0;
        seed     = 32'hc7ca;
        sh_flags = 4'h0;
        for (int k = 0; k < 4; k++) begin
            sh_regs[k] = 8'h00;
        end

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flags("fout", fout, 4'h0);
        checking = 1'b1;

        for (int k = 0; k < 5; k++) begin
            read_bus(4'(k));
        end

        load_reg(4'd0, 8'h3C);
        load_reg(4'd1, 8'hA5);
        load_reg(4'd2, 8'h7F);
        load_reg(4'd3, 8'h01);
        for (int k = 0; k < 4; k++) begin
            read_bus(4'(k));
        end
        // None of these load codes may touch a register.
        load_reg(4'd4, 8'hFF);
        load_reg(4'd5, 8'hFF);
        load_reg(4'd6, 8'hFF);
        load_reg(4'd8, 8'hFF);
        load_reg(4'hF, 8'hFF);
        for (int k = 0; k < 4; k++) begin
            read_bus(4'(k));
        end

        run_calc(alu_pkg::OUT_ADDSUB, 2'd0, 3'd1, 1'b0, 1'b0);
        run_calc(alu_pkg::OUT_ADDSUB, 2'd0, alu_pkg::ARG_R_ZERO, 1'b0, 1'b1);
        run_calc(alu_pkg::OUT_ADDSUB, 2'd0, 3'd4, 1'b0, 1'b0);
        run_calc(alu_pkg::OUT_ADDSUB, 2'd2, 3'd3, 1'b0, 1'b0);
        run_calc(alu_pkg::OUT_ADDSUB, 2'd1, 3'd0, 1'b1, 1'b1);
        run_calc(alu_pkg::OUT_ADDSUB, 2'd1, 3'd0, 1'b1, 1'b0);
        load_reg(4'd0, 8'h00);
        run_calc(alu_pkg::OUT_ADDSUB, 2'd0, 3'd3, 1'b1, 1'b1);
        run_calc(alu_pkg::OUT_ADDSUB, 2'd0, alu_pkg::ARG_R_ZERO, 1'b1, 1'b1);
        read_bus(alu_pkg::OUT_FLAGS);

        // Set C and V first so the logic ops are seen clearing both.
        run_calc(alu_pkg::OUT_ADDSUB, 2'd1, 3'd1, 1'b0, 1'b0);
        run_calc(alu_pkg::OUT_ANDOR, 2'd1, 3'd2, 1'b0, 1'b0);
        run_calc(alu_pkg::OUT_ANDOR, 2'd1, 3'd2, 1'b1, 1'b0);
        run_calc(alu_pkg::OUT_ANDOR, 2'd0, 3'd1, 1'b0, 1'b0);
        run_calc(alu_pkg::OUT_XORNOT, 2'd1, 3'd2, 1'b0, 1'b0);
        run_calc(alu_pkg::OUT_XORNOT, 2'd1, 3'd2, 1'b1, 1'b0);

        run_calc(alu_pkg::OUT_SHIFT, 2'd1, 3'd0, 1'b0, 1'b1);
        run_calc(alu_pkg::OUT_SHIFT, 2'd2, 3'd0, 1'b0, 1'b0);
        run_calc(alu_pkg::OUT_SHIFT, 2'd1, 3'd0, 1'b1, 1'b0);
        run_calc(alu_pkg::OUT_SHIFT, 2'd1, 3'd0, 1'b1, 1'b1);

        drive_cycle(alu_pkg::OUT_ADDSUB, alu_pkg::LOAD_FLAGS, 2'd2, 3'd3, 1'b0, 1'b0, 1'b0,
                    8'h00);
        drive_cycle(4'd8, alu_pkg::LOAD_FLAGS, 2'd0, 3'd0, 1'b0, 1'b0, 1'b0, 8'h0B);
        read_bus(alu_pkg::OUT_FLAGS);

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rnd = $random(seed);
            drive_cycle(rnd[3:0], rnd[7:4], rnd[9:8], rnd[12:10], rnd[13], rnd[14], rnd[15],
                        rnd[23:16]);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: alu_block.f
rtl/alu_pkg.sv
rtl/reg_file.sv
rtl/alu_core.sv
rtl/bus_driver.sv
rtl/flags_reg.sv
rtl/alu_block.sv
dv/alu_block_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$SIM_LOG"

verilator --binary --timing -j 0 \
    --timescale 1ns/10ps \
    --top-module alu_block_tb \
    -f alu_block.f > "$BUILD_LOG" 2>&1 \
    && { ./obj_dir/Valu_block_tb > "$SIM_LOG" 2>&1 || true; } \
    && grep -q "^=== PASS ===$" "$SIM_LOG" \
    && echo "Simulation passed." \
    || { echo "Simulation failed, see $BUILD_LOG and $SIM_LOG."; exit 1; }

exit 0
